// File: dv/rename_unit_tb.sv
`default_nettype none

`include "rename_defines.svh"

module rename_unit_tb;

    // per-test cycle budgets add up to the run limit
    localparam int RESET_CYC = 16;
    localparam int T1_CYC    = 2;
    localparam int T2_CYC    = 40;
    localparam int T3_CYC    = 40;
    localparam int T4_CYC    = 90;
    localparam int T5_CYC    = 35;
    localparam int T6_CYC    = 2000;
    localparam int MAX_CYC   = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC
                               + T5_CYC + T6_CYC + 200;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic [1:0]            instr_valid;
    rename_pkg::arch_reg_t rs1_arch_0;
    rename_pkg::arch_reg_t rs2_arch_0;
    rename_pkg::arch_reg_t rd_arch_0;
    rename_pkg::arch_reg_t rs1_arch_1;
    rename_pkg::arch_reg_t rs2_arch_1;
    rename_pkg::arch_reg_t rd_arch_1;
    rename_pkg::phy_reg_t  rs1_phy_0;
    rename_pkg::phy_reg_t  rs2_phy_0;
    rename_pkg::phy_reg_t  rd_phy_old_0;
    rename_pkg::phy_reg_t  rd_phy_new_0;
    rename_pkg::phy_reg_t  rs1_phy_1;
    rename_pkg::phy_reg_t  rs2_phy_1;
    rename_pkg::phy_reg_t  rd_phy_old_1;
    rename_pkg::phy_reg_t  rd_phy_new_1;
    logic                  rename_ready;
    logic [1:0]            commit_valid;
    rename_pkg::arch_reg_t commit_rd_arch_0;
    rename_pkg::arch_reg_t commit_rd_arch_1;
    rename_pkg::phy_reg_t  commit_rd_phy_0;
    rename_pkg::phy_reg_t  commit_rd_phy_1;

    // reference model with both tables, the free registers in order and the ROB
    rename_pkg::phy_reg_t  spec_map [`RN_ARCH_REGS];
    rename_pkg::phy_reg_t  comm_map [`RN_ARCH_REGS];
    rename_pkg::phy_reg_t  free_q [$];
    rename_pkg::arch_reg_t inf_arch [$];
    rename_pkg::phy_reg_t  inf_phy [$];

    int errors;
    int checks;
    int cyc;
    int err_mark;
    int n;
    rename_pkg::phy_reg_t held_old;

    rename_unit uut (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .instr_valid      (instr_valid),
        .rs1_arch_0       (rs1_arch_0),
        .rs2_arch_0       (rs2_arch_0),
        .rd_arch_0        (rd_arch_0),
        .rs1_arch_1       (rs1_arch_1),
        .rs2_arch_1       (rs2_arch_1),
        .rd_arch_1        (rd_arch_1),
        .rs1_phy_0        (rs1_phy_0),
        .rs2_phy_0        (rs2_phy_0),
        .rd_phy_old_0     (rd_phy_old_0),
        .rd_phy_new_0     (rd_phy_new_0),
        .rs1_phy_1        (rs1_phy_1),
        .rs2_phy_1        (rs2_phy_1),
        .rd_phy_old_1     (rd_phy_old_1),
        .rd_phy_new_1     (rd_phy_new_1),
        .rename_ready     (rename_ready),
        .commit_valid     (commit_valid),
        .commit_rd_arch_0 (commit_rd_arch_0),
        .commit_rd_arch_1 (commit_rd_arch_1),
        .commit_rd_phy_0  (commit_rd_phy_0),
        .commit_rd_phy_1  (commit_rd_phy_1)
    );

    always #5 clk = ~clk;

    // run limit counted in rising edges
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("timeout: run passed %0d cycles without reaching the end", MAX_CYC);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            $display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
        end
    endtask

    function automatic rename_pkg::arch_reg_t rand_arch();
        logic [31:0] r;
        r = $urandom();
        return r[`RN_ARCH_W-1:0];
    endfunction

    task automatic report_test(input string name);
        $display("test %s: %s, %0d mismatches", name,
                 (errors == err_mark) ? "pass" : "fail", errors - err_mark);
        err_mark = errors;
    endtask

    // drives one cycle at negedge and checks it just before the next posedge
    task automatic run_cycle(input logic fl, input logic [1:0] iv, input int ncm_req,
                             input bit ovl, input bit keep);
        int ncm;
        int sel;
        logic ready_exp;
        logic f0;
        logic f1;
        rename_pkg::phy_reg_t work [`RN_ARCH_REGS];
        rename_pkg::phy_reg_t e_rs1_0;
        rename_pkg::phy_reg_t e_rs2_0;
        rename_pkg::phy_reg_t e_old_0;
        rename_pkg::phy_reg_t e_rs1_1;
        rename_pkg::phy_reg_t e_rs2_1;
        rename_pkg::phy_reg_t e_old_1;
        rename_pkg::phy_reg_t new0;
        rename_pkg::phy_reg_t new1;
        @(negedge clk);
        // a held group keeps its register fields for the retry
        if (!keep) begin
            rs1_arch_0 = rand_arch();
            rs2_arch_0 = rand_arch();
            rd_arch_0  = rand_arch();
            rs1_arch_1 = rand_arch();
            rs2_arch_1 = rand_arch();
            rd_arch_1  = rand_arch();
            if (ovl) begin
                sel = $urandom_range(2, 0);
                if (sel == 0) rs1_arch_1 = rd_arch_0;
                else if (sel == 1) rs2_arch_1 = rd_arch_0;
                else begin
                    rs1_arch_1 = rd_arch_0;
                    rd_arch_1  = rd_arch_0;
                end
            end
        end
        // oldest in-flight instructions retire but never alongside a flush
        ncm = fl ? 0 : ncm_req;
        if (ncm > inf_arch.size()) ncm = inf_arch.size();
        commit_valid = (ncm == 0) ? 2'b00 : ((ncm == 1) ? 2'b01 : 2'b11);
        commit_rd_arch_0 = '0;
        commit_rd_phy_0  = '0;
        commit_rd_arch_1 = '0;
        commit_rd_phy_1  = '0;
        if (ncm >= 1) begin
            commit_rd_arch_0 = inf_arch[0];
            commit_rd_phy_0  = inf_phy[0];
        end
        if (ncm >= 2) begin
            commit_rd_arch_1 = inf_arch[1];
            commit_rd_phy_1  = inf_phy[1];
        end
        flush       = fl;
        instr_valid = iv;

        // expected rename results from the model tables
        ready_exp = (free_q.size() >= 2) && !fl;
        f0 = iv[0] & ready_exp;
        f1 = iv[1] & ready_exp;
        work = spec_map;
        new0 = (free_q.size() >= 1) ? free_q[0] : '0;
        e_rs1_0 = work[rs1_arch_0];
        e_rs2_0 = work[rs2_arch_0];
        e_old_0 = work[rd_arch_0];
        if (f0) work[rd_arch_0] = new0;
        // slot 1 takes the next entry only behind a firing slot 0
        new1 = f0 ? free_q[1] : new0;
        e_rs1_1 = work[rs1_arch_1];
        e_rs2_1 = work[rs2_arch_1];
        e_old_1 = work[rd_arch_1];
        if (f1) work[rd_arch_1] = new1;

        #4;
        check_val("rename_ready", 32'(ready_exp), 32'(rename_ready));
        check_val("rs1_phy_0", 32'(e_rs1_0), 32'(rs1_phy_0));
        check_val("rs2_phy_0", 32'(e_rs2_0), 32'(rs2_phy_0));
        check_val("rd_phy_old_0", 32'(e_old_0), 32'(rd_phy_old_0));
        check_val("rs1_phy_1", 32'(e_rs1_1), 32'(rs1_phy_1));
        check_val("rs2_phy_1", 32'(e_rs2_1), 32'(rs2_phy_1));
        check_val("rd_phy_old_1", 32'(e_old_1), 32'(rd_phy_old_1));
        // allocation outputs only mean something while entries remain
        if (free_q.size() >= 1) check_val("rd_phy_new_0", 32'(new0), 32'(rd_phy_new_0));
        if (free_q.size() >= (f0 ? 2 : 1)) begin
            check_val("rd_phy_new_1", 32'(new1), 32'(rd_phy_new_1));
        end

        // retiring sends the replaced committed mapping to the back of the list
        for (int k = 0; k < ncm; k++) begin
            free_q.push_back(comm_map[inf_arch[0]]);
            comm_map[inf_arch[0]] = inf_phy[0];
            inf_arch.delete(0);
            inf_phy.delete(0);
        end
        if (f0) begin
            free_q.delete(0);
            inf_arch.push_back(rd_arch_0);
            inf_phy.push_back(new0);
        end
        if (f1) begin
            free_q.delete(0);
            inf_arch.push_back(rd_arch_1);
            inf_phy.push_back(new1);
        end
        spec_map = work;
        // flush returns every uncommitted allocation to the front in order
        if (fl) begin
            spec_map = comm_map;
            for (int k = inf_phy.size() - 1; k >= 0; k--) free_q.push_front(inf_phy[k]);
            inf_arch.delete();
            inf_phy.delete();
        end
    endtask

    initial begin
        void'($urandom(32'hbe3a_00a1));
        errors = 0;
        checks = 0;
        cyc = 0;
        err_mark = 0;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        instr_valid = 2'b00;
        rs1_arch_0 = '0;
        rs2_arch_0 = '0;
        rd_arch_0 = '0;
        rs1_arch_1 = '0;
        rs2_arch_1 = '0;
        rd_arch_1 = '0;
        commit_valid = 2'b00;
        commit_rd_arch_0 = '0;
        commit_rd_arch_1 = '0;
        commit_rd_phy_0 = '0;
        commit_rd_phy_1 = '0;
        // model starts at the identity map with the upper half free
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            spec_map[i] = rename_pkg::phy_reg_t'(i);
            comm_map[i] = rename_pkg::phy_reg_t'(i);
            free_q.push_back(rename_pkg::phy_reg_t'(i + `RN_ARCH_REGS));
        end
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_cycle(1'b0, 2'b11, 0, 1'b0, 1'b0);
        check_val("rd_phy_new_0", 32'd32, 32'(rd_phy_new_0));
        check_val("rd_phy_new_1", 32'd33, 32'(rd_phy_new_1));
        report_test("1 reset state");

        for (n = 0; n < 30; n++) run_cycle(1'b0, 2'b11, $urandom_range(2, 0), 1'b1, 1'b0);
        for (n = 0; n < 5; n++) run_cycle(1'b0, 2'b10, $urandom_range(2, 0), 1'b1, 1'b0);
        report_test("2 two-wide rename with bypass");

        // no retires, so the list drains until a whole group cannot fit
        for (n = 0; n < 34 && free_q.size() >= 2; n++) begin
            run_cycle(1'b0, 2'($urandom_range(3, 1)), 0, 1'b1, 1'b0);
        end
        if (free_q.size() >= 2) begin
            errors = errors + 1;
            $display("free list never drained far enough to stall renaming");
        end
        run_cycle(1'b0, 2'b11, 0, 1'b0, 1'b0);
        // mapping seen by the stalled group must survive every retry
        held_old = spec_map[rd_arch_0];
        for (n = 0; n < 5; n++) begin
            run_cycle(1'b0, 2'b11, 0, 1'b0, 1'b1);
            check_val("rd_phy_old_0", 32'(held_old), 32'(rd_phy_old_0));
        end
        report_test("3 exhaustion and back-pressure");

        for (n = 0; n < 80 && inf_arch.size() > 0; n++) begin
            run_cycle(1'b0, 2'b00, $urandom_range(2, 0), 1'b0, 1'b0);
        end
        for (n = 0; n < 4; n++) run_cycle(1'b0, 2'b11, 0, 1'b0, 1'b0);
        check_val("rename_ready", 32'd1, 32'(rename_ready));
        report_test("4 commit and reuse");

        for (n = 0; n < 20; n++) begin
            run_cycle(1'b0, 2'($urandom_range(3, 0)), $urandom_range(2, 0), 1'b1, 1'b0);
        end
        run_cycle(1'b1, 2'b11, 0, 1'b0, 1'b0);
        for (n = 0; n < 10; n++) run_cycle(1'b0, 2'b11, 0, 1'b0, 1'b0);
        report_test("5 flush recovery");

        // flush in roughly one cycle out of 32
        for (n = 0; n < T6_CYC; n++) begin
            run_cycle(($urandom_range(31, 0) == 0), 2'($urandom_range(3, 0)),
                      $urandom_range(2, 0), 1'($urandom_range(1, 0)), 1'b0);
        end
        report_test("6 mixed random run");

        $display("checks %0d, mismatches %0d, cycles %0d", checks, errors, cyc);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_unit.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/front_rat.sv
verilog/commit_rat.sv
verilog/free_list.sv
verilog/rename_unit.sv
dv/rename_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the rename unit testbench with Verilator, runs it, and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module rename_unit_tb \
    -f rename_unit.f \
    -o rename_unit_sim \
    && ./obj_dir/rename_unit_sim | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verilog/commit_rat.sv
`default_nettype none

`include "rename_defines.svh"

module commit_rat (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   flush,
    input  wire logic [1:0]                             commit_valid,
    input  wire rename_pkg::arch_reg_t                  commit_rd_arch_0,
    input  wire rename_pkg::arch_reg_t                  commit_rd_arch_1,
    input  wire rename_pkg::phy_reg_t                   commit_rd_phy_0,
    input  wire rename_pkg::phy_reg_t                   commit_rd_phy_1,
    output rename_pkg::phy_reg_t                        freed_phy_0,
    output rename_pkg::phy_reg_t                        freed_phy_1,
    output logic [`RN_ARCH_REGS*`RN_PHY_W-1:0]          committed_map
);

    // architectural state as of the last retired instruction
    rename_pkg::phy_reg_t map_q [`RN_ARCH_REGS];
    rename_pkg::phy_reg_t map_work [`RN_ARCH_REGS];

    always_comb begin
        map_work = map_q;

        // the mapping being overwritten is no longer reachable
        freed_phy_0 = map_work[commit_rd_arch_0];
        if (commit_valid[0]) begin
            map_work[commit_rd_arch_0] = commit_rd_phy_0;
        end

        // slot 1 sees slot 0's commit, so a repeated rd frees slot 0's reg
        freed_phy_1 = map_work[commit_rd_arch_1];
        if (commit_valid[1]) begin
            map_work[commit_rd_arch_1] = commit_rd_phy_1;
        end
    end

    // flatten the registered table for the flush restore path
    always_comb begin
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            committed_map[i*`RN_PHY_W +: `RN_PHY_W] = map_q[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phy_reg_t'(i);
            end
        end else begin
            map_q <= map_work;
        end
    end

    // a commit during flush would leave front_rat restoring a stale table
    a_no_commit_on_flush: assert property (
        @(posedge clk) disable iff (rst)
        flush |-> (commit_valid == 2'b00)
    );

endmodule

`default_nettype wire

// File: verilog/free_list.sv
`default_nettype none

`include "rename_defines.svh"

module free_list (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       flush,
    input  wire logic [1:0]                 rename_fire,
    input  wire logic [1:0]                 commit_valid,
    input  wire rename_pkg::phy_reg_t       freed_phy_0,
    input  wire rename_pkg::phy_reg_t       freed_phy_1,
    output rename_pkg::phy_reg_t            alloc_phy_0,
    output rename_pkg::phy_reg_t            alloc_phy_1,
    output logic [`RN_PTR_W-1:0]            free_count
);

    // circular storage of register numbers
    rename_pkg::phy_reg_t list_q [`RN_FREE_REGS];

    // spec_head moves on rename, commit_head on retire, tail on free
    logic [`RN_PTR_W-1:0] spec_head_q;
    logic [`RN_PTR_W-1:0] commit_head_q;
    logic [`RN_PTR_W-1:0] tail_q;

    logic [`RN_PTR_W-1:0] spec_head_p1;
    logic [`RN_PTR_W-1:0] tail_p1;
    logic [1:0]           alloc_cnt;
    logic [1:0]           commit_cnt;

    // population counts of the two strobes
    assign alloc_cnt  = {1'b0, rename_fire[0]} + {1'b0, rename_fire[1]};
    assign commit_cnt = {1'b0, commit_valid[0]} + {1'b0, commit_valid[1]};

    assign spec_head_p1 = spec_head_q + `RN_PTR_W'(1);
    // slot 1 pushes right behind slot 0, or at the tail if slot 0 is idle
    assign tail_p1      = tail_q + `RN_PTR_W'(commit_valid[0]);

    // head and next entry for front_rat to pick from per fired slot
    assign alloc_phy_0 = list_q[spec_head_q[`RN_PTR_W-2:0]];
    assign alloc_phy_1 = list_q[spec_head_p1[`RN_PTR_W-2:0]];

    // wrap bit makes this 0 when empty and RN_FREE_REGS when full
    assign free_count = tail_q - spec_head_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // registers above the identity map start out free in order
            for (int i = 0; i < `RN_FREE_REGS; i++) begin
                list_q[i] <= rename_pkg::phy_reg_t'(i + `RN_ARCH_REGS);
            end
        end else begin
            if (commit_valid[0]) begin
                list_q[tail_q[`RN_PTR_W-2:0]] <= freed_phy_0;
            end
            if (commit_valid[1]) begin
                list_q[tail_p1[`RN_PTR_W-2:0]] <= freed_phy_1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            spec_head_q   <= '0;
            commit_head_q <= '0;
            tail_q        <= `RN_PTR_W'(`RN_FREE_REGS);
        end else begin
            // flush rewinds past every allocation not yet retired
            if (flush) begin
                spec_head_q <= commit_head_q;
            end else begin
                spec_head_q <= spec_head_q + {{(`RN_PTR_W-2){1'b0}}, alloc_cnt};
            end
            // each retire consumed exactly one allocation in rename order
            commit_head_q <= commit_head_q + {{(`RN_PTR_W-2){1'b0}}, commit_cnt};
            tail_q        <= tail_q + {{(`RN_PTR_W-2){1'b0}}, commit_cnt};
        end
    end

    // allocations beyond the tail would hand out stale entries
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        free_count <= `RN_PTR_W'(`RN_FREE_REGS)
    );

    // each push reuses a slot whose allocation retires in the same cycle
    a_push_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        {{(`RN_PTR_W-2){1'b0}}, commit_cnt} <= (spec_head_q - commit_head_q)
    );

endmodule

`default_nettype wire

// File: verilog/front_rat.sv
`default_nettype none

`include "rename_defines.svh"

module front_rat (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   flush,
    input  wire logic [1:0]                             rename_fire,
    input  wire rename_pkg::arch_reg_t                  rs1_arch_0,
    input  wire rename_pkg::arch_reg_t                  rs2_arch_0,
    input  wire rename_pkg::arch_reg_t                  rd_arch_0,
    input  wire rename_pkg::arch_reg_t                  rs1_arch_1,
    input  wire rename_pkg::arch_reg_t                  rs2_arch_1,
    input  wire rename_pkg::arch_reg_t                  rd_arch_1,
    input  wire rename_pkg::phy_reg_t                   alloc_phy_0,
    input  wire rename_pkg::phy_reg_t                   alloc_phy_1,
    input  wire logic [`RN_ARCH_REGS*`RN_PHY_W-1:0]     committed_map,
    output rename_pkg::phy_reg_t                        rs1_phy_0,
    output rename_pkg::phy_reg_t                        rs2_phy_0,
    output rename_pkg::phy_reg_t                        rd_phy_old_0,
    output rename_pkg::phy_reg_t                        rd_phy_new_0,
    output rename_pkg::phy_reg_t                        rs1_phy_1,
    output rename_pkg::phy_reg_t                        rs2_phy_1,
    output rename_pkg::phy_reg_t                        rd_phy_old_1,
    output rename_pkg::phy_reg_t                        rd_phy_new_1
);

    // speculative mapping, one entry per architectural register
    rename_pkg::phy_reg_t map_q [`RN_ARCH_REGS];
    // table after this cycle's group has been applied
    rename_pkg::phy_reg_t map_work [`RN_ARCH_REGS];

    always_comb begin
        map_work = map_q;

        // slot 0 always takes the head entry
        rd_phy_new_0 = alloc_phy_0;
        // slot 1 takes head+1 only when slot 0 consumed the head
        rd_phy_new_1 = rename_fire[0] ? alloc_phy_1 : alloc_phy_0;

        // slot 0 reads the table as it stands
        rs1_phy_0    = map_work[rs1_arch_0];
        rs2_phy_0    = map_work[rs2_arch_0];
        rd_phy_old_0 = map_work[rd_arch_0];

        if (rename_fire[0]) begin
            map_work[rd_arch_0] = rd_phy_new_0;
        end

        // slot 1 reads after slot 0's write, giving the in-group bypass
        rs1_phy_1    = map_work[rs1_arch_1];
        rs2_phy_1    = map_work[rs2_arch_1];
        rd_phy_old_1 = map_work[rd_arch_1];

        // same rd in both slots leaves slot 1 as the youngest mapping
        if (rename_fire[1]) begin
            map_work[rd_arch_1] = rd_phy_new_1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity map out of reset
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phy_reg_t'(i);
            end
        end else if (flush) begin
            // single-cycle restore from the committed table
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= committed_map[i*`RN_PHY_W +: `RN_PHY_W];
            end
        end else begin
            map_q <= map_work;
        end
    end

    // top level must hold rename_ready low while flushing
    // otherwise the restore would drop this cycle's group silently
    a_no_fire_on_flush: assert property (
        @(posedge clk) disable iff (rst)
        flush |-> (rename_fire == 2'b00)
    );

endmodule

`default_nettype wire

// File: verilog/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file as seen by software
`define RN_ARCH_REGS 32

// physical register file behind the rename stage
`define RN_PHY_REGS 64

// index widths for the two register spaces
`define RN_ARCH_W 5
`define RN_PHY_W 6

// free list holds every physical register not mapped at reset
`define RN_FREE_REGS 32

// one extra wrap bit so a full list and an empty list differ
`define RN_PTR_W 6

`endif

// File: verilog/rename_pkg.sv
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    // architectural register index, x0 included
    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;

    // physical register index
    typedef logic [`RN_PHY_W-1:0] phy_reg_t;

endpackage

`default_nettype wire

// File: verilog/rename_unit.sv
`default_nettype none

`include "rename_defines.svh"

module rename_unit (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush,
    // rename group
    input  wire logic [1:0]             instr_valid,
    input  wire rename_pkg::arch_reg_t  rs1_arch_0,
    input  wire rename_pkg::arch_reg_t  rs2_arch_0,
    input  wire rename_pkg::arch_reg_t  rd_arch_0,
    input  wire rename_pkg::arch_reg_t  rs1_arch_1,
    input  wire rename_pkg::arch_reg_t  rs2_arch_1,
    input  wire rename_pkg::arch_reg_t  rd_arch_1,
    output rename_pkg::phy_reg_t        rs1_phy_0,
    output rename_pkg::phy_reg_t        rs2_phy_0,
    output rename_pkg::phy_reg_t        rd_phy_old_0,
    output rename_pkg::phy_reg_t        rd_phy_new_0,
    output rename_pkg::phy_reg_t        rs1_phy_1,
    output rename_pkg::phy_reg_t        rs2_phy_1,
    output rename_pkg::phy_reg_t        rd_phy_old_1,
    output rename_pkg::phy_reg_t        rd_phy_new_1,
    output logic                        rename_ready,
    // retire group
    input  wire logic [1:0]             commit_valid,
    input  wire rename_pkg::arch_reg_t  commit_rd_arch_0,
    input  wire rename_pkg::arch_reg_t  commit_rd_arch_1,
    input  wire rename_pkg::phy_reg_t   commit_rd_phy_0,
    input  wire rename_pkg::phy_reg_t   commit_rd_phy_1
);

    logic [1:0]                          rename_fire;
    rename_pkg::phy_reg_t                alloc_phy_0;
    rename_pkg::phy_reg_t                alloc_phy_1;
    rename_pkg::phy_reg_t                freed_phy_0;
    rename_pkg::phy_reg_t                freed_phy_1;
    logic [`RN_ARCH_REGS*`RN_PHY_W-1:0]  committed_map;
    logic [`RN_PTR_W-1:0]                free_count;

    // whole group or nothing, so two free entries are needed
    assign rename_ready = (free_count >= `RN_PTR_W'(2)) && !flush;
    assign rename_fire  = instr_valid & {2{rename_ready}};

    front_rat u_front_rat (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .rename_fire   (rename_fire),
        .rs1_arch_0    (rs1_arch_0),
        .rs2_arch_0    (rs2_arch_0),
        .rd_arch_0     (rd_arch_0),
        .rs1_arch_1    (rs1_arch_1),
        .rs2_arch_1    (rs2_arch_1),
        .rd_arch_1     (rd_arch_1),
        .alloc_phy_0   (alloc_phy_0),
        .alloc_phy_1   (alloc_phy_1),
        .committed_map (committed_map),
        .rs1_phy_0     (rs1_phy_0),
        .rs2_phy_0     (rs2_phy_0),
        .rd_phy_old_0  (rd_phy_old_0),
        .rd_phy_new_0  (rd_phy_new_0),
        .rs1_phy_1     (rs1_phy_1),
        .rs2_phy_1     (rs2_phy_1),
        .rd_phy_old_1  (rd_phy_old_1),
        .rd_phy_new_1  (rd_phy_new_1)
    );

    commit_rat u_commit_rat (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .commit_rd_arch_0 (commit_rd_arch_0),
        .commit_rd_arch_1 (commit_rd_arch_1),
        .commit_rd_phy_0  (commit_rd_phy_0),
        .commit_rd_phy_1  (commit_rd_phy_1),
        .freed_phy_0      (freed_phy_0),
        .freed_phy_1      (freed_phy_1),
        .committed_map    (committed_map)
    );

    free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .rename_fire  (rename_fire),
        .commit_valid (commit_valid),
        .freed_phy_0  (freed_phy_0),
        .freed_phy_1  (freed_phy_1),
        .alloc_phy_0  (alloc_phy_0),
        .alloc_phy_1  (alloc_phy_1),
        .free_count   (free_count)
    );

endmodule

`default_nettype wire
